/* verilog/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // ==============================
    // Serial line timing
    // ==============================
    localparam int CLK_FREQ_HZ  = 100_000_000;               // System clock
    localparam int BAUD_RATE    = 115_200;
    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;   // 868 cycles

    // Bit timer shared by both directions
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

    localparam bit_cnt_t BIT_END = bit_cnt_t'(CLKS_PER_BIT - 1);      // Last cycle of a bit
    localparam bit_cnt_t BIT_MID = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);  // Centre of start bit

    typedef logic [7:0] byte_t;  // One serial data byte

endpackage

`default_nettype wire

/* verilog/dma_pkg.sv */
`default_nettype none

package dma_pkg;

    // ==============================
    // Frame opcodes and responses
    // ==============================
    localparam logic [7:0] OP_WRITE_UB    = 8'h01;  // Rows into unified buffer
    localparam logic [7:0] OP_WRITE_WT    = 8'h02;  // Weight memory words
    localparam logic [7:0] OP_WRITE_INSTR = 8'h03;  // One instruction
    localparam logic [7:0] OP_EXECUTE     = 8'h05;  // Start strobe
    localparam logic [7:0] OP_STATUS      = 8'h06;  // Status byte back

    localparam logic [7:0] RSP_UB_ACK  = 8'hAA;
    localparam logic [7:0] RSP_WT_ACK  = 8'hBB;
    localparam logic [7:0] RSP_BAD_CMD = 8'hFF;     // Unknown opcode

    localparam int INSTR_BYTES = 4;  // Instruction payload, no length field

    // ==============================
    // Addresses and memory words
    // ==============================
    typedef logic [7:0]   ub_addr_t;
    typedef logic [9:0]   wt_addr_t;
    typedef logic [4:0]   instr_addr_t;
    typedef logic [255:0] ub_row_t;      // 32 bytes
    typedef logic [63:0]  wt_word_t;     // 8 bytes
    typedef logic [31:0]  instr_word_t;
    typedef logic [15:0]  xfer_len_t;    // Payload byte count

    // Write requests toward the memories
    typedef struct packed {
        logic     en;
        ub_addr_t addr;
        ub_row_t  data;
    } ub_wr_t;

    typedef struct packed {
        logic     en;
        wt_addr_t addr;
        wt_word_t data;
    } wt_wr_t;

    typedef struct packed {
        logic        en;
        instr_addr_t addr;
        instr_word_t data;
    } instr_wr_t;

    // Engine flags, MSB first as sent in the status byte
    typedef struct packed {
        logic ub_done;
        logic ub_busy;
        logic vpu_done;
        logic vpu_busy;
        logic sys_done;
        logic sys_busy;
    } engine_status_t;

    typedef enum logic [2:0] {
        S_IDLE,      // Waiting for opcode
        S_ADDR_HI,
        S_ADDR_LO,
        S_LEN_HI,
        S_LEN_LO,
        S_PAYLOAD,   // Bytes steered to a packer
        S_RESP       // Holding a response byte for the transmitter
    } cmd_state_t;

endpackage

`default_nettype wire

/* verilog/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  wire   rx,
    output logic  rx_valid,
    output byte_t rx_data
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    bit_cnt_t   clk_cnt;
    logic [2:0] bit_idx;    // Data bit being sampled
    logic       rx_meta;
    logic       rx_sync;

    // Two-flop synchroniser, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ==============================
    // Bit sequencing
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync)
                        state <= RX_START;  // Falling edge
                end
                RX_START: begin
                    if (clk_cnt == BIT_MID) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // Still low, real start bit
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == BIT_END) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == BIT_END) begin
                        rx_valid <= rx_sync;  // Low stop bit drops the byte
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == BIT_END)
            rx_data <= {rx_sync, rx_data[7:1]};
    end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,
    input  wire   tx_valid,
    input  wire   byte_t tx_data,
    output logic  tx_ready,
    output logic  tx
);

    logic [9:0] frame;      // Stop, data, start; bit 0 on the line
    logic [3:0] bits_left;  // Shifts before the stop bit ends
    logic       busy;
    bit_cnt_t   clk_cnt;

    assign tx_ready = !busy;     // Only between frames
    assign tx       = frame[0];

    // ==============================
    // Frame shifter
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame     <= '1;  // Line idles high
            bits_left <= '0;
            busy      <= 1'b0;
            clk_cnt   <= '0;
        end else if (!busy) begin
            if (tx_valid) begin
                frame     <= {1'b1, tx_data, 1'b0};  // Start bit out next cycle
                bits_left <= 4'd9;
                busy      <= 1'b1;
                clk_cnt   <= '0;
            end
        end else if (clk_cnt == BIT_END) begin
            clk_cnt <= '0;
            frame   <= {1'b1, frame[9:1]};  // Backfill with idle level
            if (bits_left == 4'd0)
                busy <= 1'b0;               // Stop bit done
            else
                bits_left <= bits_left - 1'b1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/word_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module word_packer
    import uart_pkg::*;
#(
    parameter type word_t = logic [31:0],
    parameter type addr_t = logic [4:0]
) (
    input  wire   clk,
    input  wire   rst_n,
    input  wire   start,
    input  wire   addr_t base_addr,
    input  wire   byte_valid,
    input  wire   byte_t byte_data,
    input  wire   last,
    output logic  wr_en,
    output addr_t wr_addr,
    output word_t wr_data
);

    localparam int WORD_BYTES = $bits(word_t) / 8;
    localparam int FILL_W     = $clog2(WORD_BYTES);

    logic [FILL_W-1:0] fill;       // Bytes already in acc
    word_t             acc;
    word_t             acc_next;
    addr_t             addr_q;     // Address of the word being built
    logic              flush;

    // Newest byte at the bottom, first byte ends up on top
    assign acc_next = {acc[$bits(word_t)-9:0], byte_data};
    assign flush    = byte_valid && (last || fill == FILL_W'(WORD_BYTES - 1));

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en  <= 1'b0;
            fill   <= '0;
            addr_q <= '0;
        end else begin
            wr_en <= 1'b0;
            if (start) begin
                fill   <= '0;
                addr_q <= base_addr;
            end else if (flush) begin
                wr_en  <= 1'b1;
                fill   <= '0;
                addr_q <= addr_q + 1'b1;  // Wraps at the address width
            end else if (byte_valid) begin
                fill <= fill + 1'b1;
            end
        end
    end

    // Accumulator and write payload
    always_ff @(posedge clk) begin
        if (start || flush)
            acc <= '0;              // Partial word keeps zero upper bytes
        else if (byte_valid)
            acc <= acc_next;
        if (flush) begin
            wr_data <= acc_next;
            wr_addr <= addr_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/host_cmd_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module host_cmd_fsm
    import uart_pkg::*;
    import dma_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            rx_valid,
    input  wire byte_t     rx_data,
    input  wire            tx_ready,
    input  wire engine_status_t engine_status,
    output logic           tx_valid,
    output byte_t          tx_data,
    output logic           ub_start,
    output logic           wt_start,
    output logic           instr_start,
    output ub_addr_t       ub_base,
    output wt_addr_t       wt_base,
    output instr_addr_t    instr_base,
    output logic           ub_byte_valid,
    output logic           wt_byte_valid,
    output logic           instr_byte_valid,
    output byte_t          pay_byte,
    output logic           pay_last,
    output logic           start_execution
);

    cmd_state_t state;
    byte_t      opcode;
    byte_t      addr_hi;
    byte_t      addr_lo;
    xfer_len_t  length;
    xfer_len_t  pay_cnt;    // Payload bytes already taken
    logic       pay_fire;

    // ==============================
    // Payload steering
    // ==============================
    assign pay_fire = (state == S_PAYLOAD) && rx_valid;
    assign pay_byte = rx_data;                  // Same cycle as rx_valid
    assign pay_last = (pay_cnt == length - 1'b1);

    assign ub_byte_valid    = pay_fire && (opcode == OP_WRITE_UB);
    assign wt_byte_valid    = pay_fire && (opcode == OP_WRITE_WT);
    assign instr_byte_valid = pay_fire && (opcode == OP_WRITE_INSTR);

    // Base addresses out of the header bytes
    assign ub_base    = addr_lo;
    assign wt_base    = {addr_hi[1:0], addr_lo};
    assign instr_base = addr_lo[4:0];

    // ==============================
    // Command sequencing
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= S_IDLE;
            opcode          <= '0;
            addr_hi         <= '0;
            addr_lo         <= '0;
            length          <= '0;
            pay_cnt         <= '0;
            tx_valid        <= 1'b0;
            tx_data         <= '0;
            ub_start        <= 1'b0;
            wt_start        <= 1'b0;
            instr_start     <= 1'b0;
            start_execution <= 1'b0;
        end else begin
            ub_start        <= 1'b0;   // Strobes last one cycle
            wt_start        <= 1'b0;
            instr_start     <= 1'b0;
            start_execution <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (rx_valid) begin
                        opcode <= rx_data;
                        case (rx_data)
                            OP_WRITE_UB, OP_WRITE_WT, OP_WRITE_INSTR: begin
                                state <= S_ADDR_HI;
                            end
                            OP_EXECUTE: begin
                                start_execution <= 1'b1;  // No response byte
                            end
                            OP_STATUS: begin
                                tx_data  <= {2'b00, engine_status};
                                tx_valid <= 1'b1;
                                state    <= S_RESP;
                            end
                            default: begin
                                tx_data  <= RSP_BAD_CMD;
                                tx_valid <= 1'b1;
                                state    <= S_RESP;
                            end
                        endcase
                    end
                end
                S_ADDR_HI: begin
                    if (rx_valid) begin
                        addr_hi <= rx_data;
                        state   <= S_ADDR_LO;
                    end
                end
                S_ADDR_LO: begin
                    if (rx_valid) begin
                        addr_lo <= rx_data;
                        pay_cnt <= '0;
                        if (opcode == OP_WRITE_INSTR) begin
                            length      <= xfer_len_t'(INSTR_BYTES);  // Fixed size
                            instr_start <= 1'b1;
                            state       <= S_PAYLOAD;
                        end else begin
                            state <= S_LEN_HI;
                        end
                    end
                end
                S_LEN_HI: begin
                    if (rx_valid) begin
                        length[15:8] <= rx_data;
                        state        <= S_LEN_LO;
                    end
                end
                S_LEN_LO: begin
                    if (rx_valid) begin
                        length[7:0] <= rx_data;
                        ub_start    <= (opcode == OP_WRITE_UB);
                        wt_start    <= (opcode == OP_WRITE_WT);
                        state       <= S_PAYLOAD;
                    end
                end
                S_PAYLOAD: begin
                    if (rx_valid) begin
                        pay_cnt <= pay_cnt + 1'b1;
                        if (pay_last) begin
                            // Ack goes out with the packer's final write
                            if (opcode == OP_WRITE_UB) begin
                                tx_data  <= RSP_UB_ACK;
                                tx_valid <= 1'b1;
                                state    <= S_RESP;
                            end else if (opcode == OP_WRITE_WT) begin
                                tx_data  <= RSP_WT_ACK;
                                tx_valid <= 1'b1;
                                state    <= S_RESP;
                            end else begin
                                state <= S_IDLE;  // Instruction write is silent
                            end
                        end
                    end
                end
                S_RESP: begin
                    if (tx_ready) begin     // Handshake cycle
                        tx_valid <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_dma
    import uart_pkg::*;
    import dma_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            uart_rx,
    input  wire engine_status_t engine_status,
    output logic           uart_tx,
    output ub_wr_t         ub_wr,
    output wt_wr_t         wt_wr,
    output instr_wr_t      instr_wr,
    output logic           start_execution
);

    // ==============================
    // Internal links
    // ==============================
    byte_t       rx_data;
    byte_t       tx_data;
    byte_t       pay_byte;
    logic        rx_valid;
    logic        tx_valid;
    logic        tx_ready;
    logic        pay_last;
    logic        ub_start;
    logic        wt_start;
    logic        instr_start;
    logic        ub_byte_valid;
    logic        wt_byte_valid;
    logic        instr_byte_valid;
    ub_addr_t    ub_base;
    wt_addr_t    wt_base;
    instr_addr_t instr_base;

    uart_rx u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (uart_rx),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .tx       (uart_tx)
    );

    host_cmd_fsm u_cmd (
        .clk              (clk),
        .rst_n            (rst_n),
        .rx_valid         (rx_valid),
        .rx_data          (rx_data),
        .tx_ready         (tx_ready),
        .engine_status    (engine_status),
        .tx_valid         (tx_valid),
        .tx_data          (tx_data),
        .ub_start         (ub_start),
        .wt_start         (wt_start),
        .instr_start      (instr_start),
        .ub_base          (ub_base),
        .wt_base          (wt_base),
        .instr_base       (instr_base),
        .ub_byte_valid    (ub_byte_valid),
        .wt_byte_valid    (wt_byte_valid),
        .instr_byte_valid (instr_byte_valid),
        .pay_byte         (pay_byte),
        .pay_last         (pay_last),
        .start_execution  (start_execution)
    );

    // ==============================
    // One packer per memory
    // ==============================
    word_packer #(.word_t(ub_row_t), .addr_t(ub_addr_t)) u_ub_pack (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (ub_start),
        .base_addr  (ub_base),
        .byte_valid (ub_byte_valid),
        .byte_data  (pay_byte),
        .last       (pay_last),
        .wr_en      (ub_wr.en),
        .wr_addr    (ub_wr.addr),
        .wr_data    (ub_wr.data)
    );

    word_packer #(.word_t(wt_word_t), .addr_t(wt_addr_t)) u_wt_pack (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (wt_start),
        .base_addr  (wt_base),
        .byte_valid (wt_byte_valid),
        .byte_data  (pay_byte),
        .last       (pay_last),
        .wr_en      (wt_wr.en),
        .wr_addr    (wt_wr.addr),
        .wr_data    (wt_wr.data)
    );

    word_packer #(.word_t(instr_word_t), .addr_t(instr_addr_t)) u_instr_pack (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (instr_start),
        .base_addr  (instr_base),
        .byte_valid (instr_byte_valid),
        .byte_data  (pay_byte),
        .last       (pay_last),
        .wr_en      (instr_wr.en),
        .wr_addr    (instr_wr.addr),
        .wr_data    (instr_wr.data)
    );

endmodule

`default_nettype wire

/* tb/uart_dma_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_dma_tb
    import uart_pkg::*;
    import dma_pkg::*;
();

    localparam int MEM_UB    = 0;
    localparam int MEM_WT    = 1;
    localparam int MEM_INSTR = 2;

    localparam int BYTE_CYCLES = 10 * CLKS_PER_BIT;  // One serial frame

    // One memory write, widened to the largest word
    typedef struct packed {
        logic [15:0]  addr;
        logic [255:0] data;
    } mem_wr_t;

    logic           clk;
    logic           rst_n;
    logic           uart_rx;
    logic           uart_tx;
    engine_status_t engine_status;
    ub_wr_t         ub_wr;
    wt_wr_t         wt_wr;
    instr_wr_t      instr_wr;
    logic           start_execution;

    mem_wr_t ub_q[$];
    mem_wr_t wt_q[$];
    mem_wr_t instr_q[$];
    mem_wr_t exp_q[$];               // Reference write list
    byte_t   payload[$];             // Payload of the frame under test
    int      exec_count    = 0;
    int      seed;
    logic    rx_valid_prev = 1'b0;   // Receiver pulse one cycle back

    uart_dma DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .uart_rx         (uart_rx),
        .engine_status   (engine_status),
        .uart_tx         (uart_tx),
        .ub_wr           (ub_wr),
        .wt_wr           (wt_wr),
        .instr_wr        (instr_wr),
        .start_execution (start_execution)
    );

    always #5 clk = ~clk;  // 100 MHz

    // ==============================
    // Checking
    // ==============================
    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [255:0] got, input logic [255:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            fail_run();
        end
    endtask

    // Write list from the packing rule, first byte of a word on top
    function automatic void build_expected(input int base, input int addr_bits,
                                           input int word_bytes);
        mem_wr_t e;
        int      i;
        int      j;
        int      k;
        int      cnt;
        exp_q.delete();
        i = 0;
        k = 0;
        while (i < payload.size()) begin
            cnt = payload.size() - i;
            if (cnt > word_bytes)
                cnt = word_bytes;
            e.addr = 16'((base + k) % (1 << addr_bits));  // Wraps at the width
            e.data = '0;                                  // Partial word sits low
            for (j = 0; j < cnt; j++)
                e.data[8*(cnt-1-j) +: 8] = payload[i+j];
            exp_q.push_back(e);
            i += cnt;
            k++;
        end
    endfunction

    task automatic compare_writes(input int mem);
        mem_wr_t got[$];
        int      i;
        case (mem)
            MEM_UB:  got = ub_q;
            MEM_WT:  got = wt_q;
            default: got = instr_q;
        endcase
        check("write count", 256'(got.size()), 256'(exp_q.size()));
        check("writes on other memories",
              256'(ub_q.size() + wt_q.size() + instr_q.size()), 256'(got.size()));
        for (i = 0; i < got.size(); i++) begin
            check("write address", 256'(got[i].addr), 256'(exp_q[i].addr));
            check("write data", got[i].data, exp_q[i].data);
        end
        ub_q.delete();
        wt_q.delete();
        instr_q.delete();
    endtask

    // Monitors sample at the falling edge
    always @(negedge clk) begin
        mem_wr_t w;
        if (rst_n) begin
            if (ub_wr.en || wt_wr.en || instr_wr.en)
                check("write enable one cycle after rx_valid", 256'(rx_valid_prev), 256'(1));
            if (ub_wr.en) begin
                w.addr = 16'(ub_wr.addr);
                w.data = 256'(ub_wr.data);
                ub_q.push_back(w);
            end
            if (wt_wr.en) begin
                w.addr = 16'(wt_wr.addr);
                w.data = 256'(wt_wr.data);
                wt_q.push_back(w);
            end
            if (instr_wr.en) begin
                w.addr = 16'(instr_wr.addr);
                w.data = 256'(instr_wr.data);
                instr_q.push_back(w);
            end
            if (start_execution)
                exec_count++;
        end
        rx_valid_prev = DUT.rx_valid;
    end

    // ==============================
    // Serial host model
    // ==============================
    function automatic byte_t random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Start bit, data LSB first, then the given stop level
    task automatic send_byte(input byte_t b, input logic stop_bit);
        logic [9:0] frame;
        int         i;
        frame = {stop_bit, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);  // Hold one bit time
        end
    endtask

    // Header, optional length, then the payload queue
    task automatic send_write_frame(input byte_t op, input logic [15:0] addr,
                                    input logic with_len);
        logic [15:0] len;
        len = 16'(payload.size());
        send_byte(op, 1'b1);
        send_byte(addr[15:8], 1'b1);
        send_byte(addr[7:0], 1'b1);
        if (with_len) begin
            send_byte(len[15:8], 1'b1);
            send_byte(len[7:0], 1'b1);
        end
        foreach (payload[i])
            send_byte(payload[i], 1'b1);
    endtask

    // Decode one byte on uart_tx at bit centres
    task automatic receive_byte(output byte_t b, input int max_cycles);
        int i;
        int waited;
        waited = 0;
        @(negedge clk);
        while (uart_tx) begin
            if (waited == max_cycles) begin
                $display("Timeout: no start bit on uart_tx within %0d cycles", max_cycles);
                fail_run();
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        check("uart_tx start bit", 256'(uart_tx), 256'(0));
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check("uart_tx stop bit", 256'(uart_tx), 256'(1));
    endtask

    // Line must stay idle, no response byte
    task automatic expect_no_response(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check("uart_tx idle", 256'(uart_tx), 256'(1));
        end
    endtask

    task automatic wait_for_writes(input int n, input int max_cycles);
        int waited;
        waited = 0;
        while (ub_q.size() + wt_q.size() + instr_q.size() < n) begin
            if (waited == max_cycles) begin
                $display("Timeout: fewer than %0d memory writes seen", n);
                fail_run();
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        byte_t          rsp;
        byte_t          op;
        byte_t          r8;
        engine_status_t st;
        int             i;
        int             waited;

        seed          = 59570;
        clk           = 1'b0;
        rst_n         = 1'b0;
        uart_rx       = 1'b1;   // Line idles high
        engine_status = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet outputs out of reset
        @(negedge clk);
        check("uart_tx after reset", 256'(uart_tx), 256'(1));
        check("ub_wr.en after reset", 256'(ub_wr.en), 256'(0));
        check("wt_wr.en after reset", 256'(wt_wr.en), 256'(0));
        check("instr_wr.en after reset", 256'(instr_wr.en), 256'(0));
        check("start_execution after reset", 256'(start_execution), 256'(0));

        // UB rows, 40 bytes at 0x10
        payload.delete();
        for (i = 0; i < 40; i++)
            payload.push_back(random_byte());
        build_expected(16'h0010, 8, 32);
        fork
            send_write_frame(OP_WRITE_UB, 16'h0010, 1'b1);
            receive_byte(rsp, 47 * BYTE_CYCLES);
        join
        check("UB ack byte", 256'(rsp), 256'(RSP_UB_ACK));
        compare_writes(MEM_UB);

        // Weight words, 20 bytes at 0x3FE, wraps to 0
        payload.delete();
        for (i = 0; i < 20; i++)
            payload.push_back(random_byte());
        build_expected(16'h03FE, 10, 8);
        fork
            send_write_frame(OP_WRITE_WT, 16'h03FE, 1'b1);
            receive_byte(rsp, 27 * BYTE_CYCLES);
        join
        check("weight ack byte", 256'(rsp), 256'(RSP_WT_ACK));
        compare_writes(MEM_WT);

        // One instruction at 7, silent
        payload.delete();
        for (i = 0; i < 4; i++)
            payload.push_back(random_byte());
        build_expected(7, 5, 4);
        send_write_frame(OP_WRITE_INSTR, 16'h0007, 1'b0);
        wait_for_writes(1, BYTE_CYCLES);
        expect_no_response(2 * BYTE_CYCLES);
        compare_writes(MEM_INSTR);

        // Execute strobe
        send_byte(OP_EXECUTE, 1'b1);
        waited = 0;
        while (exec_count == 0) begin
            if (waited == BYTE_CYCLES) begin
                $display("Timeout: no start_execution pulse after the execute opcode");
                fail_run();
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        expect_no_response(2 * BYTE_CYCLES);   // Also a window for extra pulses
        check("start_execution pulses", 256'(exec_count), 256'(1));
        check("writes after execute",
              256'(ub_q.size() + wt_q.size() + instr_q.size()), 256'(0));

        // Status byte, flags held stable
        r8 = random_byte();
        st = r8[5:0];
        @(posedge clk);
        engine_status <= st;
        fork
            send_byte(OP_STATUS, 1'b1);
            receive_byte(rsp, 3 * BYTE_CYCLES);
        join
        check("status byte", 256'(rsp), 256'({2'b00, st}));

        // Low stop bit, byte must vanish
        send_byte(OP_STATUS, 1'b0);
        @(posedge clk);
        uart_rx <= 1'b1;
        expect_no_response(2 * BYTE_CYCLES);

        // Unknown opcode
        op = random_byte();
        while (op inside {OP_WRITE_UB, OP_WRITE_WT, OP_WRITE_INSTR, OP_EXECUTE, OP_STATUS})
            op = random_byte();
        fork
            send_byte(op, 1'b1);
            receive_byte(rsp, 3 * BYTE_CYCLES);
        join
        check("unknown opcode response", 256'(rsp), 256'(RSP_BAD_CMD));

        // Status still answers
        r8 = random_byte();
        st = r8[5:0];
        @(posedge clk);
        engine_status <= st;
        fork
            send_byte(OP_STATUS, 1'b1);
            receive_byte(rsp, 3 * BYTE_CYCLES);
        join
        check("status byte after bad frame", 256'(rsp), 256'({2'b00, st}));
        check("stray writes", 256'(ub_q.size() + wt_q.size() + instr_q.size()), 256'(0));
        check("start_execution pulses at end", 256'(exec_count), 256'(1));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/uart_pkg.sv
verilog/dma_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/word_packer.sv
verilog/host_cmd_fsm.sv
verilog/uart_dma.sv
tb/uart_dma_tb.sv

/* Makefile */
# Verilator build and run of the UART host bridge testbench

VERILATOR ?= verilator
TOP       ?= uart_dma_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
